/* compile.f */
common/isa_pkg.sv
common/ctrl_pkg.sv
src/core_ctrl.sv
src/reg_file.sv
src/alu.sv
src/pc_unit.sv
src/writeback_path.sv
src/cpu_core.sv
verif/cpu_core_props.sv
verif/cpu_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= cpu_core_tb
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_MSG := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

/* verif/cpu_core_tb.sv */
module cpu_core_tb;
	import isa_pkg::*;

	localparam int PERIOD = 40;
	localparam int MEM_BYTES = 256;
	localparam int RUN_LIMIT = MEM_BYTES + 8; // Cycles allowed for one program
	localparam int MAX_RUNS = 16;
	localparam data_t TARGET = 8'hF0; // Landing address of taken branches

	logic clk;
	logic rst;
	data_t instr;
	logic [7:0] pc;
	data_t out_data;
	logic out_valid;
	flags_t flags;

	data_t imem [MEM_BYTES];
	int prog_addr;
	data_t m_reg [4]; // Reference model registers
	logic [3:0] m_flags; // Reference model {v, c, n, z}
	logic [11:0] expect_q [$]; // {flags, out_data} of each OUT
	int seed;

	cpu_core #(
		.ADDR_W (8)
	) cpu_core_i (
		.clk       (clk),
		.rst       (rst),
		.instr     (instr),
		.pc        (pc),
		.out_data  (out_data),
		.out_valid (out_valid),
		.flags     (flags)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Instruction memory read, updated on the falling edge
	initial begin
		instr = 8'h00;
		forever begin
			@(negedge clk);
			instr <= imem[pc];
		end
	end

	initial begin
		#(MAX_RUNS * RUN_LIMIT * PERIOD * 2);
		abort_run("Watchdog expired before all tests finished");
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic compare(input string name, input data_t expected, input data_t actual);
		if (expected !== actual) begin
			abort_run($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
		end
	endtask

	// Opcodes 6, 13, 14 and 15 are unused so stray fetches act as NOPs
	function automatic data_t undef_byte(input logic [7:0] addr);
		logic [3:0] op;
		case (addr[7:6])
			2'd0: op = 4'd6;
			2'd1: op = 4'd13;
			2'd2: op = 4'd14;
			default: op = 4'd15;
		endcase
		return {op, addr[3:0] ^ {addr[5:4], addr[5:4]}};
	endfunction

	task automatic clear_program();
		for (int i = 0; i < MEM_BYTES; i++) begin
			imem[i] = undef_byte(8'(i));
		end
		for (int i = 0; i < 4; i++) begin
			m_reg[i] = 8'h00;
		end
		prog_addr = 0;
		m_flags = 4'h0;
		expect_q.delete();
	endtask

	task automatic put_byte(input data_t b);
		imem[prog_addr] = b;
		prog_addr++;
	endtask

	task automatic ldm_imm(input reg_addr_t r, input data_t value);
		put_byte({OP_LONG, LONG_LDM, r});
		put_byte(value);
		m_reg[r] = value;
	endtask

	// Emits one ALU instruction and updates the model
	task automatic exec_op(input opcode_t op, input reg_addr_t ra, input reg_addr_t rb);
		data_t a;
		data_t b;
		data_t r;
		logic c;
		logic v;
		logic upd;
		reg_addr_t dest;
		a = m_reg[ra];
		b = m_reg[rb];
		c = m_flags[2];
		v = m_flags[3];
		upd = 1'b1;
		dest = ra;
		put_byte({op, ra, rb});
		case (op)
			OP_ADD: begin
				{c, r} = {1'b0, a} + {1'b0, b};
				v = (a[7] == b[7]) && (r[7] != a[7]);
			end
			OP_SUB: begin
				r = a - b;
				c = (a < b); // Borrow
				v = (a[7] != b[7]) && (r[7] != a[7]);
			end
			OP_AND: r = a & b;
			OP_OR: r = a | b;
			OP_UNARY: begin
				dest = rb;
				case (ra)
					UN_NOT: r = ~b;
					UN_NEG: begin
						r = 8'd0 - b;
						c = (b != 8'h00);
						v = (b == 8'h80);
					end
					UN_INC: begin
						r = b + 8'd1;
						c = (b == 8'hFF);
						v = (b == 8'h7F);
					end
					default: begin
						r = b - 8'd1;
						c = (b == 8'h00);
						v = (b == 8'h80);
					end
				endcase
			end
			default: begin
				r = b; // MOV
				upd = 1'b0;
			end
		endcase
		m_reg[dest] = r;
		if (upd) begin
			m_flags = {v, c, r[7], r == 8'h00};
		end
	endtask

	task automatic out_reg(input reg_addr_t rb);
		put_byte({OP_IO, IO_OUT, rb});
		expect_q.push_back({m_flags, m_reg[rb]});
	endtask

	task automatic apply_reset();
		@(negedge clk);
		rst = 1'b0;
		repeat (2) @(negedge clk);
		rst = 1'b1;
	endtask

	// Waits for every expected OUT and checks data and flags
	task automatic collect_outputs(input string name);
		logic [11:0] exp;
		int cycles;
		cycles = 0;
		while (expect_q.size() > 0) begin
			@(negedge clk);
			cycles++;
			if (out_valid) begin
				exp = expect_q.pop_front();
				compare({name, "_data"}, exp[7:0], out_data);
				compare({name, "_flags"}, {4'h0, exp[11:8]}, {4'h0, flags});
			end else if (cycles > RUN_LIMIT) begin
				abort_run($sformatf("%s did not produce all expected OUT results", name));
			end
		end
	endtask

	task automatic run_program(input string name);
		apply_reset();
		collect_outputs(name);
	endtask

	task automatic reset_and_nop();
		clear_program();
		for (int i = 0; i < 8; i++) begin
			put_byte(8'h00);
		end
		apply_reset();
		compare("reset_pc", 8'h00, pc);
		compare("reset_out_valid", 8'h00, {7'h00, out_valid});
		compare("reset_flags", 8'h00, {4'h0, flags});
		for (int i = 1; i <= 8; i++) begin
			@(negedge clk);
			compare("nop_pc", 8'(i), pc);
		end
	endtask

	task automatic ldm_and_out();
		clear_program();
		ldm_imm(2'd0, 8'hA5);
		ldm_imm(2'd1, 8'h3C);
		ldm_imm(2'd2, 8'h5A);
		ldm_imm(2'd3, 8'hFF);
		for (int i = 0; i < 4; i++) begin
			out_reg(reg_addr_t'(i));
		end
		apply_reset();
		@(negedge clk);
		compare("ldm_pc_first", 8'h01, pc);
		@(negedge clk);
		compare("ldm_pc_second", 8'h02, pc);
		collect_outputs("ldm_out");
	endtask

	task automatic two_reg_ops();
		clear_program();
		ldm_imm(2'd0, 8'h7F);
		ldm_imm(2'd1, 8'h01);
		exec_op(OP_ADD, 2'd0, 2'd1); // Signed overflow
		out_reg(2'd0);
		ldm_imm(2'd0, 8'hFF);
		exec_op(OP_ADD, 2'd0, 2'd1); // Carry and zero
		out_reg(2'd0);
		ldm_imm(2'd0, 8'h05);
		ldm_imm(2'd1, 8'h07);
		exec_op(OP_SUB, 2'd0, 2'd1); // Borrow
		out_reg(2'd0);
		ldm_imm(2'd0, 8'h80);
		ldm_imm(2'd1, 8'h01);
		exec_op(OP_SUB, 2'd0, 2'd1);
		out_reg(2'd0);
		ldm_imm(2'd0, 8'hF0);
		ldm_imm(2'd1, 8'h3C);
		exec_op(OP_AND, 2'd0, 2'd1); // C and V carried over
		out_reg(2'd0);
		exec_op(OP_OR, 2'd0, 2'd1);
		out_reg(2'd0);
		exec_op(OP_MOV, 2'd3, 2'd0);
		out_reg(2'd3);
		exec_op(OP_AND, 2'd2, 2'd1);
		out_reg(2'd2);
		run_program("two_reg");
	endtask

	task automatic unary_ops();
		clear_program();
		exec_op(OP_UNARY, UN_NEG, 2'd1); // NEG of zero
		out_reg(2'd1);
		ldm_imm(2'd1, 8'h80);
		exec_op(OP_UNARY, UN_NEG, 2'd1);
		out_reg(2'd1);
		ldm_imm(2'd2, 8'hFF);
		exec_op(OP_UNARY, UN_INC, 2'd2);
		out_reg(2'd2);
		ldm_imm(2'd3, 8'h55);
		exec_op(OP_UNARY, UN_NOT, 2'd3);
		out_reg(2'd3);
		exec_op(OP_UNARY, UN_DEC, 2'd3);
		out_reg(2'd3);
		ldm_imm(2'd0, 8'h7F);
		exec_op(OP_UNARY, UN_INC, 2'd0);
		out_reg(2'd0);
		run_program("unary");
	endtask

	// DEC of R0 sets or clears the flag under test
	task automatic branch_case(input string name, input logic jump, input reg_addr_t brx,
		input logic set);
		data_t x;
		clear_program();
		ldm_imm(2'd1, 8'h11);
		ldm_imm(2'd2, 8'h22);
		ldm_imm(2'd3, TARGET);
		if (!set) begin
			x = (brx == BR_JC) ? 8'h81 : 8'h02; // JC sees N set, C clear
		end else if (brx == BR_JZ) begin
			x = 8'h01;
		end else if (brx == BR_JN) begin
			x = 8'h81; // N alone
		end else if (brx == BR_JV) begin
			x = 8'h80;
		end else begin
			x = 8'h00;
		end
		ldm_imm(2'd0, x);
		exec_op(OP_UNARY, UN_DEC, 2'd0);
		put_byte(jump ? {OP_JUMP, JU_JMP, 2'd3} : {OP_BRANCH, brx, 2'd3});
		put_byte({OP_IO, IO_OUT, 2'd1}); // Fall-through path
		imem[TARGET] = {OP_IO, IO_OUT, 2'd2};
		expect_q.push_back({m_flags, (jump || set) ? 8'h22 : 8'h11});
		run_program(name);
	endtask

	task automatic branch_ops();
		for (int i = 0; i < 4; i++) begin
			branch_case($sformatf("branch%0d_set", i), 1'b0, reg_addr_t'(i), 1'b1);
			branch_case($sformatf("branch%0d_clear", i), 1'b0, reg_addr_t'(i), 1'b0);
		end
		branch_case("jmp", 1'b1, JU_JMP, 1'b0); // All flags clear
		clear_program();
		ldm_imm(2'd1, 8'h11);
		put_byte(8'h6A);
		put_byte(8'hC5); // LONG group with ra 1
		put_byte(8'h74);
		put_byte(8'hB7); // JUMP group with ra 1
		put_byte(8'hD0);
		put_byte(8'hF3);
		out_reg(2'd1);
		run_program("undefined_nop");
	endtask

	task automatic random_ops();
		opcode_t ops [5];
		data_t a;
		data_t b;
		reg_addr_t ra;
		reg_addr_t rb;
		int pick;
		ops = '{OP_MOV, OP_ADD, OP_SUB, OP_AND, OP_OR};
		clear_program();
		for (int i = 0; i < 40; i++) begin
			a = 8'($random(seed));
			b = 8'($random(seed));
			ra = 2'($random(seed));
			rb = 2'($random(seed));
			pick = int'($unsigned($random(seed)) % 5);
			ldm_imm(ra, a);
			ldm_imm(rb, b);
			exec_op(ops[pick], ra, rb);
			out_reg(ra);
		end
		run_program("random_ops");
	endtask

	initial begin
		rst = 1'b0;
		seed = 75953;
		ldm_and_out();
		two_reg_ops();
		reset_and_nop(); // Core left with nonzero pc and flags
		unary_ops();
		branch_ops();
		random_ops();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

/* verif/cpu_core_props.sv */
module cpu_core_props (
	input logic                 clk,
	input logic                 rst,
	input ctrl_pkg::dec_state_t state,
	input logic                 wr_en,
	input logic                 branch_taken,
	input logic                 out_en
);
	import ctrl_pkg::*;

	// LDM immediate byte lasts one cycle
	second_byte_returns: assert property (
		@(posedge clk) disable iff (!rst)
		state == SECOND_BYTE |=> state == FIRST_BYTE
	) else $error("Decoder stayed in SECOND_BYTE");

	no_write_on_branch: assert property (
		@(posedge clk) disable iff (!rst)
		!(wr_en && branch_taken)
	) else $error("Register write and branch in the same cycle");

	no_write_on_out: assert property (
		@(posedge clk) disable iff (!rst)
		!(out_en && wr_en)
	) else $error("OUT and register write in the same cycle");

endmodule

bind core_ctrl cpu_core_props props_i (
	.clk          (clk),
	.rst          (rst),
	.state        (state),
	.wr_en        (wr_en),
	.branch_taken (branch_taken),
	.out_en       (out_en)
);

/* src/cpu_core.sv */
module cpu_core #(
	parameter int ADDR_W = 8
) (
	input  logic              clk,
	input  logic              rst,
	input  isa_pkg::data_t    instr,
	output logic [ADDR_W-1:0] pc,
	output isa_pkg::data_t    out_data,
	output logic              out_valid,
	output isa_pkg::flags_t   flags
);
	import isa_pkg::*;
	import ctrl_pkg::*;

	reg_addr_t ra_addr;
	reg_addr_t rb_addr;
	reg_addr_t wr_addr;
	logic      wr_en;
	alu_op_t   alu_op;
	logic      flag_en;
	wb_sel_t   wb_sel;
	logic      out_en;
	logic      branch_taken;
	data_t     ra_data;
	data_t     rb_data;
	data_t     result;
	data_t     wr_data;

	core_ctrl core_ctrl_i (
		.clk          (clk),
		.rst          (rst),
		.instr        (instr),
		.flags        (flags),
		.ra_addr      (ra_addr),
		.rb_addr      (rb_addr),
		.wr_addr      (wr_addr),
		.wr_en        (wr_en),
		.alu_op       (alu_op),
		.flag_en      (flag_en),
		.wb_sel       (wb_sel),
		.out_en       (out_en),
		.branch_taken (branch_taken)
	);

	reg_file reg_file_i (
		.clk     (clk),
		.rst     (rst),
		.ra_addr (ra_addr),
		.rb_addr (rb_addr),
		.wr_addr (wr_addr),
		.wr_en   (wr_en),
		.wr_data (wr_data),
		.ra_data (ra_data),
		.rb_data (rb_data)
	);

	alu alu_i (
		.clk     (clk),
		.rst     (rst),
		.alu_op  (alu_op),
		.flag_en (flag_en),
		.a       (ra_data),
		.b       (rb_data),
		.result  (result),
		.flags   (flags)
	);

	pc_unit #(
		.ADDR_W (ADDR_W)
	) pc_unit_i (
		.clk          (clk),
		.rst          (rst),
		.branch_taken (branch_taken),
		.target       (rb_data), // Branches jump to R[rb]
		.pc           (pc)
	);

	writeback_path writeback_path_i (
		.clk        (clk),
		.rst        (rst),
		.wb_sel     (wb_sel),
		.alu_result (result),
		.imm        (instr), // LDM immediate byte
		.out_en     (out_en),
		.out_src    (rb_data),
		.wr_data    (wr_data),
		.out_data   (out_data),
		.out_valid  (out_valid)
	);

endmodule

/* src/writeback_path.sv */
module writeback_path (
	input  logic              clk,
	input  logic              rst,
	input  ctrl_pkg::wb_sel_t wb_sel,
	input  isa_pkg::data_t    alu_result,
	input  isa_pkg::data_t    imm,
	input  logic              out_en,
	input  isa_pkg::data_t    out_src,
	output isa_pkg::data_t    wr_data,
	output isa_pkg::data_t    out_data,
	output logic              out_valid
);
	import ctrl_pkg::*;

	assign wr_data = (wb_sel == WB_IMM) ? imm : alu_result;

	// Output port holds its value until the next OUT
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			out_data <= '0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= out_en; // One-cycle strobe
			if (out_en) begin
				out_data <= out_src;
			end
		end
	end

endmodule

/* src/pc_unit.sv */
module pc_unit #(
	parameter int ADDR_W = 8
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              branch_taken,
	input  isa_pkg::data_t    target,
	output logic [ADDR_W-1:0] pc
);
	import isa_pkg::*;

	logic [ADDR_W-1:0] pc_nxt;

	// Jump target uses the low bits of the register
	assign pc_nxt = branch_taken ? ADDR_W'(target) : pc + ADDR_W'(1);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			pc <= '0;
		end else begin
			pc <= pc_nxt; // Wraps at the top
		end
	end

endmodule

/* src/alu.sv */
module alu (
	input  logic              clk,
	input  logic              rst,
	input  ctrl_pkg::alu_op_t alu_op,
	input  logic              flag_en,
	input  isa_pkg::data_t    a,
	input  isa_pkg::data_t    b,
	output isa_pkg::data_t    result,
	output isa_pkg::flags_t   flags
);
	import isa_pkg::*;
	import ctrl_pkg::*;

	data_t      x; // Adder operands
	data_t      y;
	logic       sub; // Subtract instead of add
	logic       arith; // Op also updates C and V
	logic [8:0] sum;
	flags_t     flags_nxt;

	// All arithmetic ops share one adder
	always_comb begin
		x = a;
		y = b;
		sub = 1'b0;
		arith = 1'b0;
		case (alu_op)
			ALU_ADD: begin
				arith = 1'b1;
			end
			ALU_SUB: begin
				sub = 1'b1;
				arith = 1'b1;
			end
			ALU_INC: begin
				x = b;
				y = 8'd1;
				arith = 1'b1;
			end
			ALU_DEC: begin
				x = b;
				y = 8'd1;
				sub = 1'b1;
				arith = 1'b1;
			end
			ALU_NEG: begin
				x = '0; // 0 - b
				y = b;
				sub = 1'b1;
				arith = 1'b1;
			end
			default: begin
			end
		endcase
	end

	assign sum = sub ? ({1'b0, x} - {1'b0, y}) : ({1'b0, x} + {1'b0, y}); // Bit 8 is carry or borrow

	always_comb begin
		case (alu_op)
			ALU_ADD, ALU_SUB, ALU_NEG, ALU_INC, ALU_DEC: result = sum[7:0];
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_NOT: result = ~b;
			default: result = b; // MOV path
		endcase
	end

	always_comb begin
		flags_nxt = flags; // Logic ops keep C and V
		flags_nxt.z = (result == '0);
		flags_nxt.n = result[7];
		if (arith) begin
			flags_nxt.c = sum[8];
			// Same effective operand signs, result sign differs
			flags_nxt.v = (x[7] == (y[7] ^ sub)) && (result[7] != x[7]);
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			flags <= '0;
		end else if (flag_en) begin
			flags <= flags_nxt;
		end
	end

endmodule

/* src/reg_file.sv */
module reg_file (
	input  logic               clk,
	input  logic               rst,
	input  isa_pkg::reg_addr_t ra_addr,
	input  isa_pkg::reg_addr_t rb_addr,
	input  isa_pkg::reg_addr_t wr_addr,
	input  logic               wr_en,
	input  isa_pkg::data_t     wr_data,
	output isa_pkg::data_t     ra_data,
	output isa_pkg::data_t     rb_data
);
	import isa_pkg::*;

	data_t regs [4]; // R0 to R3

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int i = 0; i < 4; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Asynchronous read ports
	assign ra_data = regs[ra_addr];
	assign rb_data = regs[rb_addr];

endmodule

/* src/core_ctrl.sv */
module core_ctrl (
	input  logic                clk,
	input  logic                rst,
	input  isa_pkg::data_t      instr,
	input  isa_pkg::flags_t     flags,
	output isa_pkg::reg_addr_t  ra_addr,
	output isa_pkg::reg_addr_t  rb_addr,
	output isa_pkg::reg_addr_t  wr_addr,
	output logic                wr_en,
	output ctrl_pkg::alu_op_t   alu_op,
	output logic                flag_en,
	output ctrl_pkg::wb_sel_t   wb_sel,
	output logic                out_en,
	output logic                branch_taken
);
	import isa_pkg::*;
	import ctrl_pkg::*;

	dec_state_t state;
	dec_state_t next_state;
	reg_addr_t  ldm_rb; // Destination of the pending LDM
	logic       ldm_start;
	opcode_t    opcode;
	reg_addr_t  ra;
	reg_addr_t  rb;

	assign opcode = opcode_t'(instr[7:4]);
	assign ra = instr[3:2]; // Also the brx field
	assign rb = instr[1:0];

	assign ra_addr = ra;
	assign rb_addr = rb;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= FIRST_BYTE;
		end else begin
			state <= next_state;
		end
	end

	always_ff @(posedge clk) begin
		if (ldm_start) begin
			ldm_rb <= rb; // Held over the immediate byte
		end
	end

	always_comb begin
		next_state = FIRST_BYTE;
		ldm_start = 1'b0;
		wr_addr = ra; // Two-register ops write ra
		wr_en = 1'b0;
		alu_op = ALU_PASS_B;
		flag_en = 1'b0;
		wb_sel = WB_ALU;
		out_en = 1'b0;
		branch_taken = 1'b0;

		if (state == SECOND_BYTE) begin
			// instr now carries the immediate
			wr_addr = ldm_rb;
			wr_en = 1'b1;
			wb_sel = WB_IMM;
		end else begin
			case (opcode)
				OP_MOV: begin
					wr_en = 1'b1; // PASS_B, flags untouched
				end
				OP_ADD, OP_SUB, OP_AND, OP_OR: begin
					wr_en = 1'b1;
					flag_en = 1'b1;
					case (opcode)
						OP_ADD: alu_op = ALU_ADD;
						OP_SUB: alu_op = ALU_SUB;
						OP_AND: alu_op = ALU_AND;
						default: alu_op = ALU_OR;
					endcase
				end
				OP_IO: begin
					out_en = (ra == IO_OUT); // Other IO codes are NOPs
				end
				OP_UNARY: begin
					wr_addr = rb; // Unary ops write back to rb
					wr_en = 1'b1;
					flag_en = 1'b1;
					case (ra)
						UN_NOT: alu_op = ALU_NOT;
						UN_NEG: alu_op = ALU_NEG;
						UN_INC: alu_op = ALU_INC;
						default: alu_op = ALU_DEC;
					endcase
				end
				OP_BRANCH: begin
					case (ra)
						BR_JZ: branch_taken = flags.z;
						BR_JN: branch_taken = flags.n;
						BR_JC: branch_taken = flags.c;
						default: branch_taken = flags.v;
					endcase
				end
				OP_JUMP: begin
					branch_taken = (ra == JU_JMP);
				end
				OP_LONG: begin
					if (ra == LONG_LDM) begin
						ldm_start = 1'b1;
						next_state = SECOND_BYTE;
					end
				end
				default: begin
					// NOP and unused encodings
				end
			endcase
		end
	end

endmodule

/* common/ctrl_pkg.sv */
package ctrl_pkg;

	// ALU function select driven by the decoder
	typedef enum logic [3:0] {
		ALU_PASS_B = 4'd0, // Result is operand b
		ALU_ADD    = 4'd1,
		ALU_SUB    = 4'd2,
		ALU_AND    = 4'd3,
		ALU_OR     = 4'd4,
		ALU_NOT    = 4'd5, // Unary ops work on b
		ALU_NEG    = 4'd6,
		ALU_INC    = 4'd7,
		ALU_DEC    = 4'd8
	} alu_op_t;

	// Register write data source
	typedef enum logic {
		WB_ALU = 1'b0,
		WB_IMM = 1'b1 // Second byte of LDM
	} wb_sel_t;

	// Decoder state for two-byte instructions
	typedef enum logic {
		FIRST_BYTE  = 1'b0,
		SECOND_BYTE = 1'b1
	} dec_state_t;

endpackage

/* common/isa_pkg.sv */
package isa_pkg;

	typedef logic [7:0] data_t; // Data or instruction byte
	typedef logic [1:0] reg_addr_t; // ra / rb field

	// Upper nibble of the instruction byte
	typedef enum logic [3:0] {
		OP_NOP    = 4'd0,
		OP_MOV    = 4'd1,
		OP_ADD    = 4'd2,
		OP_SUB    = 4'd3,
		OP_AND    = 4'd4,
		OP_OR     = 4'd5,
		OP_IO     = 4'd7,
		OP_UNARY  = 4'd8,
		OP_BRANCH = 4'd9,
		OP_JUMP   = 4'd11,
		OP_LONG   = 4'd12
	} opcode_t;

	typedef struct packed {
		logic v; // Signed overflow
		logic c; // Carry or borrow
		logic n; // Result bit 7
		logic z; // Result zero
	} flags_t;

	// Sub-opcodes in the ra field
	localparam logic [1:0] UN_NOT = 2'd0;
	localparam logic [1:0] UN_NEG = 2'd1;
	localparam logic [1:0] UN_INC = 2'd2;
	localparam logic [1:0] UN_DEC = 2'd3;
	localparam logic [1:0] IO_OUT = 2'd2;
	localparam logic [1:0] JU_JMP = 2'd0;
	localparam logic [1:0] LONG_LDM = 2'd0;
	localparam logic [1:0] BR_JZ = 2'd0; // brx field shares ra bits
	localparam logic [1:0] BR_JN = 2'd1;
	localparam logic [1:0] BR_JC = 2'd2;
	localparam logic [1:0] BR_JV = 2'd3;

endpackage
